// File: hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int tag_w = 20;
    localparam int index_w = 7;
    localparam int offset_w = 5;
    localparam int sets = 128;
    localparam int words_per_line = 8;

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [offset_w-3:0] word_sel_t;   // byte offset minus the 2 byte bits

    // word 0 sits in the low bits
    typedef logic [words_per_line-1:0][word_w-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    function automatic tag_t addr_tag(logic [addr_w-1:0] a);
        return a[addr_w-1 -: tag_w];
    endfunction

    function automatic index_t addr_index(logic [addr_w-1:0] a);
        return a[offset_w +: index_w];
    endfunction

    function automatic word_sel_t addr_word(logic [addr_w-1:0] a);
        return a[offset_w-1:2];
    endfunction

    function automatic logic [addr_w-1:0] line_addr(tag_t t, index_t i);
        return {t, i, {offset_w{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

    import cache_pkg::*;

    // processor request, op = 1 for store
    typedef struct packed {
        logic              op;
        logic [3:0]        wstrb;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] wdata;
    } cpu_req_t;

    // full line write to memory
    typedef struct packed {
        logic [addr_w-1:0] addr;
        line_t             data;
    } mem_wr_t;

    // everything the memory side needs for one miss
    typedef struct packed {
        logic              dirty;
        logic [addr_w-1:0] addr;          // rebuilt from the stored tag
        line_t             line;
        logic [addr_w-1:0] refill_addr;
    } victim_t;

endpackage

`default_nettype wire

// File: hw/sdp_ram.sv
`default_nettype none
`timescale 1ns/1ps

module sdp_ram
    import cache_pkg::*;
#(
    parameter type entry_t = line_t,
    parameter int  depth = sets
) (
    input  logic   clk,
    input  logic   we,
    input  index_t waddr,
    input  entry_t wdata,
    input  index_t raddr,
    output entry_t rdata
);

    entry_t mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old value on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: hw/req_stage.sv
`default_nettype none
`timescale 1ns/1ps

module req_stage
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     valid,
    input  cpu_req_t req,
    input  logic     stall,
    output logic     addr_ok,
    output logic     pend_valid,
    output cpu_req_t pend,
    output index_t   ram_index
);

    logic accept;

    assign addr_ok = valid && !stall;
    assign accept = addr_ok;

    // control part, holds under stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (!stall) begin
            pend_valid <= accept;
        end
    end

    // payload part
    always_ff @(posedge clk) begin
        if (accept) begin
            pend <= req;
        end
    end

    // keep the RAM outputs steady while the core is busy
    assign ram_index = stall ? addr_index(pend.addr) : addr_index(req.addr);

endmodule

`default_nettype wire

// File: hw/dcache_core.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_core
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              pend_valid,
    input  cpu_req_t          pend,
    input  index_t            ram_index,
    input  logic              refill_valid,
    input  line_t             refill_line,
    output logic              stall,
    output logic              data_ok,
    output logic [word_w-1:0] rdata,
    output logic              cache_miss,
    output logic              miss_start,
    output victim_t           victim
);

    typedef enum logic [1:0] {
        s_lookup,
        s_miss,
        s_fill,
        s_done
    } state_t;

    state_t state;

    tagv_t tagv_q [2];
    line_t data_q [2];
    logic [1:0] way_we;
    line_t line_wdata;
    tagv_t tagv_wdata;

    logic [sets-1:0] valid_q [2];
    logic [sets-1:0] dirty_q [2];
    logic [sets-1:0] lru_q;    // way to replace next

    index_t idx;
    tag_t tag;
    word_sel_t word;
    logic [1:0] hit;
    logic lookup;
    logic any_hit;
    logic hit_way;
    logic miss;
    logic vway;
    logic fill;

    function automatic line_t merge_word(line_t line, word_sel_t sel, logic [3:0] strb,
                                         logic [word_w-1:0] d);
        line_t m;
        m = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[sel][8*b +: 8] = d[8*b +: 8];
            end
        end
        return m;
    endfunction

    assign idx = addr_index(pend.addr);
    assign tag = addr_tag(pend.addr);
    assign word = addr_word(pend.addr);

    assign lookup = (state == s_lookup) && pend_valid;   // compare cycle
    assign any_hit = |hit;
    assign hit_way = hit[1];
    assign miss = lookup && !any_hit;
    assign vway = lru_q[idx];
    assign fill = (state == s_miss) && refill_valid;

    for (genvar w = 0; w < 2; w++) begin : g_way
        sdp_ram #(
            .entry_t (line_t),
            .depth   (sets)
        ) data_ram (
            .clk   (clk),
            .we    (way_we[w]),
            .waddr (idx),
            .wdata (line_wdata),
            .raddr (ram_index),
            .rdata (data_q[w])
        );

        sdp_ram #(
            .entry_t (tagv_t),
            .depth   (sets)
        ) tag_ram (
            .clk   (clk),
            .we    (way_we[w]),
            .waddr (idx),
            .wdata (tagv_wdata),
            .raddr (ram_index),
            .rdata (tagv_q[w])
        );

        // RAM valid bit is X until first written, the flop copy masks it
        assign hit[w] = tagv_q[w].valid && valid_q[w][idx] && (tagv_q[w].tag == tag);
    end

    // store hit merges into the hit line, refill goes to the victim way
    always_comb begin
        way_we = '0;
        line_wdata = refill_line;
        if (lookup && any_hit && pend.op) begin
            way_we[hit_way] = 1'b1;
            line_wdata = merge_word(data_q[hit_way], word, pend.wstrb, pend.wdata);
        end else if (fill) begin
            way_we[vway] = 1'b1;
            if (pend.op) begin
                line_wdata = merge_word(refill_line, word, pend.wstrb, pend.wdata);
            end
        end
    end

    assign tagv_wdata = '{valid: 1'b1, tag: tag};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_lookup;
        end else begin
            case (state)
                s_lookup: begin
                    if (miss) begin
                        state <= s_miss;
                    end else if (lookup && pend.op) begin
                        state <= s_done;   // store hit
                    end
                end
                s_miss: begin
                    if (refill_valid) begin
                        state <= s_fill;
                    end
                end
                s_fill: state <= s_done;
                default: state <= s_lookup;   // s_done lets req_stage drop the old request
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
        end else begin
            if (lookup && any_hit) begin
                lru_q[idx] <= !hit_way;
                if (pend.op) begin
                    dirty_q[hit_way][idx] <= 1'b1;
                end
            end
            if (fill) begin
                lru_q[idx] <= !vway;
                valid_q[vway][idx] <= 1'b1;
                dirty_q[vway][idx] <= pend.op;   // store miss leaves the line dirty
            end
        end
    end

    assign stall = (state == s_miss) || (state == s_fill) || (lookup && (pend.op || !any_hit));

    assign data_ok = (lookup && any_hit) || fill;
    assign rdata = fill ? refill_line[word] : data_q[hit_way][word];
    assign cache_miss = miss;
    assign miss_start = miss;

    assign victim.dirty = dirty_q[vway][idx];
    assign victim.addr = line_addr(tagv_q[vway].tag, idx);
    assign victim.line = data_q[vway];
    assign victim.refill_addr = line_addr(tag, idx);

endmodule

`default_nettype wire

// File: hw/mem_port.sv
`default_nettype none
`timescale 1ns/1ps

module mem_port
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              miss_start,
    input  victim_t           victim,
    input  logic              wr_rdy,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  line_t             ret_data,
    output logic              wr_req,
    output mem_wr_t           wr,
    output logic              rd_req,
    output logic [addr_w-1:0] rd_addr,
    output logic              refill_valid,
    output line_t             refill_line
);

    typedef enum logic [1:0] {
        m_idle,
        m_wb,
        m_rreq,
        m_wait
    } mstate_t;

    mstate_t state;
    victim_t wb_q;   // write-back buffer

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= m_idle;
        end else begin
            case (state)
                m_idle: begin
                    if (miss_start) begin
                        state <= victim.dirty ? m_wb : m_rreq;
                    end
                end
                m_wb: begin
                    if (wr_rdy) begin
                        state <= m_rreq;
                    end
                end
                m_rreq: begin
                    if (rd_rdy) begin
                        state <= m_wait;
                    end
                end
                default: begin
                    if (ret_valid) begin
                        state <= m_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && miss_start) begin
            wb_q <= victim;
        end
    end

    assign wr_req = (state == m_wb) && wr_rdy;   // one cycle, only when accepted
    assign wr = '{addr: wb_q.addr, data: wb_q.line};

    assign rd_req = (state == m_rreq);
    assign rd_addr = wb_q.refill_addr;

    assign refill_valid = (state == m_wait) && ret_valid;
    assign refill_line = ret_data;

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_top
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  cpu_req_t          req,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [word_w-1:0] rdata,
    output logic              cache_miss,
    output logic              rd_req,
    output logic [addr_w-1:0] rd_addr,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  line_t             ret_data,
    output logic              wr_req,
    output mem_wr_t           wr,
    input  logic              wr_rdy
);

    logic     stall;
    logic     pend_valid;
    cpu_req_t pend;
    index_t   ram_index;
    logic     miss_start;
    victim_t  victim;
    logic     refill_valid;
    line_t    refill_line;

    req_stage req_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .req        (req),
        .stall      (stall),
        .addr_ok    (addr_ok),
        .pend_valid (pend_valid),
        .pend       (pend),
        .ram_index  (ram_index)
    );

    dcache_core dcache_core_inst (
        .clk          (clk),
        .reset        (reset),
        .pend_valid   (pend_valid),
        .pend         (pend),
        .ram_index    (ram_index),
        .refill_valid (refill_valid),
        .refill_line  (refill_line),
        .stall        (stall),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .cache_miss   (cache_miss),
        .miss_start   (miss_start),
        .victim       (victim)
    );

    mem_port mem_port_inst (
        .clk          (clk),
        .reset        (reset),
        .miss_start   (miss_start),
        .victim       (victim),
        .wr_rdy       (wr_rdy),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr           (wr),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .refill_valid (refill_valid),
        .refill_line  (refill_line)
    );

endmodule

`default_nettype wire

// File: bench/dcache_properties.sv
`default_nettype none
`timescale 1ns/1ps

module dcache_properties
    import cache_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic              valid,
    input logic              addr_ok,
    input logic              data_ok,
    input logic              rd_req,
    input logic              rd_rdy,
    input logic [addr_w-1:0] rd_addr,
    input logic              wr_req,
    input logic              wr_rdy
);

    int fail_count = 0;   // read by the testbench
    logic [1:0] open_q;   // accepted accesses still waiting for data_ok

    always_ff @(posedge clk) begin
        if (reset) begin
            open_q <= '0;
        end else begin
            open_q <= open_q + 2'(valid && addr_ok) - 2'(data_ok);
        end
    end

    wr_with_rdy: assert property (@(posedge clk) disable iff (reset) wr_req |-> wr_rdy)
        else begin
            fail_count++;
            $error("wr_req without wr_rdy");
        end

    rd_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            fail_count++;
            $error("rd_req dropped or changed before rd_rdy");
        end

    no_accept_in_read: assert property (@(posedge clk) disable iff (reset) rd_req |-> !addr_ok)
        else begin
            fail_count++;
            $error("addr_ok while rd_req is high");
        end

    // data_ok only for an open access, and closes it before the next one opens
    data_ok_owned: assert property (@(posedge clk) disable iff (reset) data_ok |-> open_q != 0)
        else begin
            fail_count++;
            $error("data_ok without an accepted access");
        end

    data_ok_once: assert property (@(posedge clk) disable iff (reset)
        valid && addr_ok && open_q != 0 |-> data_ok)
        else begin
            fail_count++;
            $error("new access accepted before data_ok of the previous one");
        end

endmodule

bind dcache_top dcache_properties dcache_properties_inst (.*);

`default_nettype wire

// File: bench/tb_dcache_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dcache_top
    import cache_pkg::*;
    import bus_pkg::*;
();

    localparam int n_directed = 18;
    localparam int n_random = 300;
    localparam int timeout_ns = 8 * (16 + 400 * (n_directed + n_random));

    logic clk = 1'b0;
    logic reset, valid, addr_ok, data_ok, cache_miss;
    logic rd_req, rd_rdy, ret_valid, wr_req, wr_rdy;
    cpu_req_t req;
    logic [word_w-1:0] rdata;
    logic [addr_w-1:0] rd_addr;
    line_t ret_data;
    mem_wr_t wr;

    logic [31:0] mem [16384];   // 64 KiB backing store
    tag_t ref_tag [sets][2];
    line_t ref_line [sets][2];
    logic ref_valid [sets][2] = '{default: '0};
    logic ref_dirty [sets][2] = '{default: '0};
    logic ref_lru [sets] = '{default: '0};
    mem_wr_t exp_wr_q [$];
    logic [addr_w-1:0] exp_rd_q [$];
    int rd_delay = 0;
    logic [addr_w-1:0] rd_line;

    dcache_top dcache_top_inst (.*);

    always #4 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input logic [word_w-1:0] got, input logic [word_w-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_run($sformatf("** Error @ %0t: %s rdata %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_wr(input mem_wr_t got, input mem_wr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error @ %0t: write to %h line %h, expected %h line %h",
                               $time, got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    task automatic check_addr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error @ %0t: rd_addr %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic line_t mem_line(input logic [addr_w-1:0] a);
        line_t l;
        for (int i = 0; i < words_per_line; i++) begin
            l[i] = mem[{a[15:5], 3'(i)}];
        end
        return l;
    endfunction

    function automatic line_t store_bytes(input line_t l, input cpu_req_t r);
        for (int b = 0; b < 4; b++) begin
            if (r.wstrb[b]) begin
                l[r.addr[4:2]][8*b +: 8] = r.wdata[8*b +: 8];
            end
        end
        return l;
    endfunction

    // reference cache that also queues the expected memory traffic
    task automatic ref_access(input cpu_req_t r, output logic hit, output logic [31:0] exp_data);
        index_t idx;
        tag_t tg;
        logic w;
        mem_wr_t wb;
        idx = r.addr[11:5];
        tg = r.addr[31:12];
        hit = 1'b0;
        w = ref_lru[idx];
        for (int i = 0; i < 2; i++) begin
            if (ref_valid[idx][i] && ref_tag[idx][i] == tg) begin
                hit = 1'b1;
                w = i[0];
            end
        end
        if (!hit) begin
            if (ref_valid[idx][w] && ref_dirty[idx][w]) begin
                wb.addr = {ref_tag[idx][w], idx, 5'b0};
                wb.data = ref_line[idx][w];
                exp_wr_q.push_back(wb);
            end
            exp_rd_q.push_back({tg, idx, 5'b0});
            ref_line[idx][w] = mem_line(r.addr);
            ref_tag[idx][w] = tg;
            ref_valid[idx][w] = 1'b1;
            ref_dirty[idx][w] = 1'b0;
        end
        exp_data = ref_line[idx][w][r.addr[4:2]];
        if (r.op) begin
            ref_line[idx][w] = store_bytes(ref_line[idx][w], r);
            ref_dirty[idx][w] = 1'b1;
        end
        ref_lru[idx] = !w;
    endtask

    // one access from posedge+1 to posedge+1
    task automatic do_access(input logic op, input logic [3:0] strb,
                             input logic [addr_w-1:0] addr, input logic [word_w-1:0] data);
        cpu_req_t r;
        logic hit;
        logic [word_w-1:0] exp_data;
        int n;
        r = '{op: op, wstrb: strb, addr: addr, wdata: data};
        ref_access(r, hit, exp_data);
        valid = 1'b1;
        req = r;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        req = '0;
        n = 1;
        @(negedge clk);
        check_flag(cache_miss, !hit, "cache_miss in compare cycle");
        while (!data_ok) begin
            @(negedge clk);
            n++;
        end
        if (hit && n != 1) begin
            stop_run($sformatf("hit at %h answered after %0d cycles instead of one", addr, n));
        end
        if (!op) begin
            check_word(rdata, exp_data, "load");
        end
        if (exp_wr_q.size() != 0 || exp_rd_q.size() != 0) begin
            stop_run($sformatf("access to %h ended before its memory traffic", addr));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag(addr_ok, 1'b0, "addr_ok after reset");
        check_flag(data_ok, 1'b0, "data_ok after reset");
        check_flag(cache_miss, 1'b0, "cache_miss after reset");
        check_flag(rd_req, 1'b0, "rd_req after reset");
        check_flag(wr_req, 1'b0, "wr_req after reset");
        @(posedge clk);
        #1;
    endtask

    task automatic test_stores();
        do_access(1'b1, 4'b0011, 32'h0000_0104, 32'hdead_beef);   // hit
        do_access(1'b0, 4'b0000, 32'h0000_0104, 32'h0);
        do_access(1'b1, 4'b1010, 32'h0000_0108, 32'h1234_5678);
        do_access(1'b0, 4'b0000, 32'h0000_0108, 32'h0);
        do_access(1'b1, 4'b0100, 32'h0000_2244, 32'h00ab_0000);   // miss
        do_access(1'b0, 4'b0000, 32'h0000_2244, 32'h0);
        do_access(1'b1, 4'b1111, 32'h0000_2240, 32'hcafe_f00d);
        do_access(1'b0, 4'b0000, 32'h0000_2240, 32'h0);
    endtask

    // set 20 with four tags
    task automatic test_lru();
        do_access(1'b0, 4'b0000, 32'h0000_1280, 32'h0);
        do_access(1'b1, 4'b0001, 32'h0000_2284, 32'h0000_0077);
        do_access(1'b0, 4'b0000, 32'h0000_1280, 32'h0);
        do_access(1'b0, 4'b0000, 32'h0000_3280, 32'h0);   // dirty victim
        do_access(1'b0, 4'b0000, 32'h0000_4280, 32'h0);   // clean victim
        do_access(1'b0, 4'b0000, 32'h0000_2284, 32'h0);
    endtask

    task automatic test_random();
        logic [addr_w-1:0] a;
        for (int i = 0; i < n_random; i++) begin
            a = {17'b0, 3'($urandom % 8), 7'(($urandom % 4) * 41), 3'($urandom % 8), 2'b00};
            do_access(1'($urandom % 2), 4'($urandom), a, $urandom);
        end
    endtask

    // memory model sampled mid-cycle
    initial begin
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_data = '0;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                if (exp_wr_q.size() == 0) begin
                    stop_run("memory write without a dirty victim");
                end else begin
                    check_wr(wr, exp_wr_q.pop_front());
                    for (int i = 0; i < words_per_line; i++) begin
                        mem[{wr.addr[15:5], 3'(i)}] = wr.data[i];
                    end
                end
            end
            if (rd_req && rd_rdy) begin
                if (exp_rd_q.size() == 0) begin
                    stop_run("memory read without a miss");
                end else begin
                    check_addr(rd_addr, exp_rd_q.pop_front());
                    rd_line = rd_addr;
                    rd_delay = 1 + $urandom % 6;
                end
            end
            @(posedge clk);
            #1;
            ret_valid = 1'b0;
            if (rd_delay > 0) begin
                rd_delay--;
                ret_valid = (rd_delay == 0);
                ret_data = mem_line(rd_line);
            end
            rd_rdy = ($urandom % 4) != 0;
            wr_rdy = ($urandom % 4) != 0;
        end
    end

    always @(negedge clk) begin
        if (dcache_top_inst.dcache_properties_inst.fail_count != 0) begin
            stop_run("a bound assertion on the cache strobes failed");
        end
    end

    initial begin
        #(timeout_ns);
        stop_run("watchdog expired, the cache stopped answering");
    end

    initial begin
        void'($urandom(68752));
        reset = 1'b1;
        valid = 1'b0;
        req = '0;
        for (int i = 0; i < 16384; i++) begin
            mem[i] = $urandom;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        do_access(1'b0, 4'b0000, 32'h0000_0104, 32'h0);   // first load misses
        do_access(1'b0, 4'b0000, 32'h0000_8a3c, 32'h0);
        do_access(1'b0, 4'b0000, 32'h0000_0118, 32'h0);   // same line hits
        do_access(1'b0, 4'b0000, 32'h0000_8a20, 32'h0);
        test_stores();
        test_lru();
        test_random();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/cache_pkg.sv
hw/bus_pkg.sv
hw/sdp_ram.sv
hw/req_stage.sv
hw/dcache_core.sv
hw/mem_port.sv
hw/dcache_top.sv
bench/dcache_properties.sv
bench/tb_dcache_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
sim: build
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
